//--- design/cartMapper_cfg.svh
//====================================================================
// Fixed widths of the Game Boy cartridge bus and the load image
// Image addresses cover 512 banks of 16 KiB
// Cartridge RAM covers at most 16 banks of 8 KiB
// Header byte addresses are image addresses in bank 0
//====================================================================
`ifndef CART_MAPPER_CFG_SVH
`define CART_MAPPER_CFG_SVH

// Load image address, 512 banks of 16 KiB
`define IMG_AW 23

// Cartridge RAM address, 16 banks of 8 KiB
`define RAM_AW 17

// CPU side of the cartridge slot
`define CPU_AW 16
`define DW 8

// Header bytes probed after reset
`define HDR_TYPE 23'h000147
`define HDR_ROM 23'h000148
`define HDR_RAM 23'h000149

`endif

//--- design/cartMapperPkg.sv
//====================================================================
// Shared types of the cartridge bank controller
// Only ROM-only, MBC1 and MBC5 mappers are modelled
// Every other cartridge type decodes to mkUnsupported
//====================================================================
package cartMapperPkg;

    // Mapper family taken from header byte 0x147
    typedef enum logic [1:0]
    {
        mkRomOnly,
        mkMbc1,
        mkMbc5,
        mkUnsupported
    } mapperKind;

    // Router decode of one CPU request
    typedef enum logic [1:0]
    {
        tgtRom,
        tgtRam,
        tgtReg,
        tgtNone
    } busTarget;

    // Decoded cartridge header
    // romSize holds the raw code 0..8, bank count is 2 << romSize
    // ramSize is in ascending order, 4 is 64 KiB and 5 is 128 KiB
    typedef struct packed
    {
        mapperKind kind;
        logic [3:0] romSize;
        logic [2:0] ramSize;
        logic hasRam;
    } cartCfg;

endpackage

//--- design/bankIf.sv
//====================================================================
// Bank register state shared between register block and translator
// No clock, all fields are registered inside bankRegs
//====================================================================
interface bankIf;

    // Up to 512 ROM banks of 16 KiB
    logic [8:0] romBank;
    // Up to 16 RAM banks, MBC1 uses the low 2 bits only
    logic [3:0] ramBank;
    logic ramEnabled;
    // MBC1 banking mode from 0x6000-0x7FFF
    logic bankingMode;

    modport driver (output romBank, ramBank, ramEnabled, bankingMode);
    modport reader (input romBank, ramBank, ramEnabled, bankingMode);

endinterface

//--- design/headerProbe.sv
//====================================================================
// Reads header bytes 0x147, 0x148 and 0x149 once after reset
// Each read waits for its own response, so latency may vary
// ROM codes above 8 fall back to code 0
// RAM codes above 5 fall back to no RAM
//====================================================================
`include "cartMapper_cfg.svh"

module headerProbe
(
    input logic Clk,
    input logic rstN,
    output logic probeValid,
    output logic [`IMG_AW-1:0] probeAddr,
    input logic probeReady,
    input logic probeRspValid,
    input logic [`DW-1:0] probeData,
    output cartMapperPkg::cartCfg cfg,
    output logic probeDone
);
    import cartMapperPkg::*;

    typedef enum logic [1:0] {psIdle, psReq, psWait, psDone} probeState;

    probeState state;
    // Header byte index 0..2
    logic [1:0] step;

    // Cartridge type to mapper family
    function automatic mapperKind decodeKind(input logic [`DW-1:0] cartType);
        case (cartType)
            8'h00, 8'h08, 8'h09: decodeKind = mkRomOnly;
            8'h01, 8'h02, 8'h03: decodeKind = mkMbc1;
            8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E: decodeKind = mkMbc5;
            default: decodeKind = mkUnsupported;
        endcase
    endfunction

    // Raw codes 4 and 5 swap so size rises with the code
    function automatic logic [2:0] normRam(input logic [`DW-1:0] code);
        case (code)
            8'h00, 8'h01, 8'h02, 8'h03: normRam = code[2:0];
            8'h04: normRam = 3'd5;
            8'h05: normRam = 3'd4;
            default: normRam = 3'd0;
        endcase
    endfunction

    assign probeValid = (state == psReq);
    assign probeDone = (state == psDone);

    always_comb
    begin
        case (step)
            2'd0: probeAddr = `HDR_TYPE;
            2'd1: probeAddr = `HDR_ROM;
            default: probeAddr = `HDR_RAM;
        endcase
    end

    //====================================================================
    // Read sequencer and capture
    //====================================================================
    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            state <= psIdle;
            step <= 2'd0;
            cfg <= '{kind: mkRomOnly, romSize: 4'd0, ramSize: 3'd0, hasRam: 1'b0};
        end
        else
        begin
            case (state)
                psIdle: state <= psReq;
                // Address stays put until the image port takes it
                psReq: if (probeReady) state <= psWait;
                psWait:
                    if (probeRspValid)
                    begin
                        step <= step + 2'd1;
                        state <= (step == 2'd2) ? psDone : psReq;
                        case (step)
                            2'd0:
                            begin
                                cfg.kind <= decodeKind(probeData);
                                cfg.hasRam <= probeData inside
                                    {8'h02, 8'h03, 8'h08, 8'h09, 8'h1A, 8'h1B, 8'h1D, 8'h1E};
                            end
                            2'd1: cfg.romSize <= (probeData <= 8'd8) ? probeData[3:0] : 4'd0;
                            default: cfg.ramSize <= normRam(probeData);
                        endcase
                    end
                default: state <= psDone;
            endcase
        end
    end

endmodule

//--- design/bankRegs.sv
//====================================================================
// Mapper register writes for ROM-only, MBC1 and MBC5
// Writes only arrive for CPU addresses 0x0000-0x7FFF
// Unsupported cartridges ignore every write
// New values are visible on the cycle after regWrite
//====================================================================
`include "cartMapper_cfg.svh"

module bankRegs
(
    input logic Clk,
    input logic rstN,
    input cartMapperPkg::cartCfg cfg,
    input logic regWrite,
    input logic [`CPU_AW-1:0] regAddr,
    input logic [`DW-1:0] regData,
    bankIf.driver bank
);
    import cartMapperPkg::*;

    logic [9:0] bankCount;
    logic [8:0] romMask;
    logic [4:0] mbc1Low;

    // Bank count is 2 << code, code 8 wraps to 0 and the mask to all ones
    assign bankCount = 10'd2 << cfg.romSize;
    assign romMask = bankCount[8:0] - 9'd1;

    // MBC1 never selects bank 0 through the low field
    assign mbc1Low = (regData[4:0] == 5'd0) ? 5'd1 : regData[4:0];

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            bank.romBank <= 9'd1;
            bank.ramBank <= 4'd0;
            bank.ramEnabled <= 1'b0;
            bank.bankingMode <= 1'b0;
        end
        else if (regWrite && cfg.kind != mkUnsupported)
        begin
            case (regAddr[15:13])
                // RAM enable, any value other than 0xA disables
                3'b000: bank.ramEnabled <= (regData[3:0] == 4'hA);
                3'b001:
                    if (cfg.kind == mkMbc1)
                        bank.romBank <= {4'd0, mbc1Low & romMask[4:0]};
                    else if (cfg.kind == mkMbc5)
                    begin
                        // MBC5 splits the bank number at 0x3000
                        if (!regAddr[12])
                            bank.romBank[7:0] <= regData & romMask[7:0];
                        else
                            bank.romBank[8] <= regData[0] & romMask[8];
                    end
                3'b010:
                    if (cfg.kind == mkMbc1)
                        bank.ramBank <= {2'd0, regData[1:0]};
                    else if (cfg.kind == mkMbc5)
                        bank.ramBank <= regData[3:0];
                3'b011:
                    if (cfg.kind == mkMbc1)
                        bank.bankingMode <= regData[0];
                default: ;
            endcase
        end
    end

endmodule

//--- design/bankTranslate.sv
//====================================================================
// Combinational translation of a CPU address to image and RAM space
// Both results are masked to the sizes from the header
// MBC1 multi-cart wiring is not modelled
//====================================================================
`include "cartMapper_cfg.svh"

module bankTranslate
(
    input cartMapperPkg::cartCfg cfg,
    bankIf.reader bank,
    input logic [`CPU_AW-1:0] cpuAddr,
    output logic [`IMG_AW-1:0] imgAddr,
    output logic [`RAM_AW-1:0] ramAddr
);
    import cartMapperPkg::*;

    logic [9:0] bankCount;
    logic [8:0] romMask;
    logic [8:0] bankNum;
    logic [3:0] ramSel;
    logic [`RAM_AW-1:0] ramMask;
    logic largeRom;

    assign bankCount = 10'd2 << cfg.romSize;
    assign romMask = bankCount[8:0] - 9'd1;
    // 1 MiB and up, MBC1 routes ramBank to bits 20:19
    assign largeRom = (cfg.romSize >= 4'd5);

    always_comb
    begin
        if (!cpuAddr[14])
            // Lower window is bank 0 apart from MBC1 mode 1
            bankNum = (cfg.kind == mkMbc1 && bank.bankingMode && largeRom) ?
                {2'd0, bank.ramBank[1:0], 5'd0} : 9'd0;
        else if (cfg.kind == mkMbc1)
            bankNum = {2'd0, largeRom ? bank.ramBank[1:0] : 2'd0, bank.romBank[4:0]};
        else if (cfg.kind == mkMbc5)
            bankNum = bank.romBank;
        else
            bankNum = 9'd1;
    end

    assign imgAddr = {bankNum & romMask, cpuAddr[13:0]};

    // MBC1 banks RAM only in mode 1 with 32 KiB RAM on a small ROM
    assign ramSel = (cfg.kind == mkMbc1 &&
                     !(bank.bankingMode && cfg.ramSize >= 3'd3 && !largeRom)) ?
                    4'd0 : bank.ramBank;

    always_comb
    begin
        case (cfg.ramSize)
            3'd1: ramMask = 17'h007FF;
            3'd2: ramMask = 17'h01FFF;
            3'd3: ramMask = 17'h07FFF;
            3'd4: ramMask = 17'h0FFFF;
            3'd5: ramMask = 17'h1FFFF;
            default: ramMask = 17'h00000;
        endcase
    end

    assign ramAddr = {ramSel, cpuAddr[12:0]} & ramMask;

endmodule

//--- design/busRouter.sv
//====================================================================
// One CPU request in flight at a time
// Image port belongs to the header probe until probeDone
// Register writes, unmapped addresses and disabled RAM answer in 1 cycle
// Memory reads answer 1 cycle after the memory response
//====================================================================
`include "cartMapper_cfg.svh"

module busRouter
(
    input logic Clk,
    input logic rstN,
    input cartMapperPkg::cartCfg cfg,
    input logic ramEnabled,
    input logic probeDone,
    // CPU side
    input logic busValid,
    output logic busReady,
    input logic busWrite,
    input logic [`CPU_AW-1:0] busAddr,
    input logic [`DW-1:0] busWData,
    output logic rspValid,
    output logic [`DW-1:0] rspData,
    // Image side
    output logic romValid,
    input logic romReady,
    output logic [`IMG_AW-1:0] romAddr,
    input logic romRspValid,
    input logic [`DW-1:0] romData,
    // Cartridge RAM side
    output logic ramValid,
    input logic ramReady,
    output logic ramWrite,
    output logic [`RAM_AW-1:0] ramAddr,
    output logic [`DW-1:0] ramWData,
    input logic ramRspValid,
    input logic [`DW-1:0] ramRData,
    // Header probe channel
    input logic probeValid,
    input logic [`IMG_AW-1:0] probeAddr,
    output logic probeReady,
    output logic probeRspValid,
    output logic [`DW-1:0] probeData,
    // Register block and translator
    output logic regWrite,
    output logic [`CPU_AW-1:0] regAddr,
    output logic [`DW-1:0] regData,
    input logic [`IMG_AW-1:0] imgAddr,
    input logic [`RAM_AW-1:0] ramMapAddr,
    output logic [`CPU_AW-1:0] cpuAddr
);
    import cartMapperPkg::*;

    busTarget target;
    busTarget tgt;
    logic active;
    // Memory handshake done, waiting for data
    logic issued;
    logic accept;
    logic cpuRomValid;
    logic memDone;
    logic [`CPU_AW-1:0] reqAddr;
    logic [`DW-1:0] reqData;
    logic reqWrite;

    assign busReady = probeDone && !active;
    assign accept = busValid && busReady;

    // Writes below 0x8000 hit mapper registers
    always_comb
    begin
        if (!busAddr[15])
            target = busWrite ? tgtReg : tgtRom;
        else if (busAddr[15:13] == 3'b101 && cfg.hasRam && ramEnabled)
            target = tgtRam;
        else
            target = tgtNone;
    end

    //====================================================================
    // Memory handshakes
    //====================================================================
    assign cpuRomValid = active && tgt == tgtRom && !issued;
    assign romValid = probeDone ? cpuRomValid : probeValid;
    assign romAddr = probeDone ? imgAddr : probeAddr;
    assign probeReady = !probeDone && romReady;
    assign probeRspValid = !probeDone && romRspValid;
    assign probeData = romData;

    assign ramValid = active && tgt == tgtRam && !issued;
    assign ramWrite = ramValid && reqWrite;
    assign ramAddr = ramMapAddr;
    assign ramWData = reqData;

    assign memDone = active && issued &&
                     ((tgt == tgtRom && romRspValid) || (tgt == tgtRam && ramRspValid));

    assign cpuAddr = reqAddr;
    assign regAddr = reqAddr;
    assign regData = reqData;

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            active <= 1'b0;
            issued <= 1'b0;
            tgt <= tgtNone;
            rspValid <= 1'b0;
            regWrite <= 1'b0;
        end
        else
        begin
            rspValid <= 1'b0;
            regWrite <= 1'b0;
            if (accept)
            begin
                active <= 1'b1;
                issued <= 1'b0;
                tgt <= target;
                rspValid <= (target == tgtReg || target == tgtNone);
                regWrite <= (target == tgtReg);
            end
            // Free the bus the cycle after the response pulse
            else if (rspValid)
                active <= 1'b0;
            else if ((cpuRomValid && probeDone && romReady) || (ramValid && ramReady))
                issued <= 1'b1;
            else if (memDone)
                rspValid <= 1'b1;
        end
    end

    // Request and response payload
    always_ff @(posedge Clk)
    begin
        if (accept)
        begin
            reqAddr <= busAddr;
            reqData <= busWData;
            reqWrite <= busWrite;
            rspData <= '0;
        end
        else if (memDone)
            rspData <= (tgt == tgtRom) ? romData : (reqWrite ? '0 : ramRData);
    end

endmodule

//--- design/cartMapper.sv
//====================================================================
// Game Boy cartridge bank controller, ROM-only, MBC1 and MBC5
// CPU, image and RAM sides are valid/ready with response strobes
// busReady stays low until the header probe finishes
//====================================================================
`include "cartMapper_cfg.svh"

module cartMapper
(
    input logic Clk,
    input logic rstN,
    // CPU request and response
    input logic busValid,
    output logic busReady,
    input logic busWrite,
    input logic [`CPU_AW-1:0] busAddr,
    input logic [`DW-1:0] busWData,
    output logic rspValid,
    output logic [`DW-1:0] rspData,
    // Load image reads
    output logic romValid,
    input logic romReady,
    output logic [`IMG_AW-1:0] romAddr,
    input logic romRspValid,
    input logic [`DW-1:0] romData,
    // Cartridge RAM
    output logic ramValid,
    input logic ramReady,
    output logic ramWrite,
    output logic [`RAM_AW-1:0] ramAddr,
    output logic [`DW-1:0] ramWData,
    input logic ramRspValid,
    input logic [`DW-1:0] ramRData
);
    import cartMapperPkg::*;

    cartCfg cfg;
    logic probeDone;
    logic probeValid;
    logic probeReady;
    logic probeRspValid;
    logic [`IMG_AW-1:0] probeAddr;
    logic [`DW-1:0] probeData;
    logic regWrite;
    logic [`CPU_AW-1:0] regAddr;
    logic [`DW-1:0] regData;
    logic [`CPU_AW-1:0] cpuAddr;
    logic [`IMG_AW-1:0] imgAddr;
    logic [`RAM_AW-1:0] ramMapAddr;

    bankIf bankBus ();

    headerProbe probe0 (.Clk, .rstN, .probeValid, .probeAddr, .probeReady,
                        .probeRspValid, .probeData, .cfg, .probeDone);

    bankRegs regs0 (.Clk, .rstN, .cfg, .regWrite, .regAddr, .regData, .bank(bankBus));

    bankTranslate xlate0 (.cfg, .bank(bankBus), .cpuAddr, .imgAddr, .ramAddr(ramMapAddr));

    busRouter router0 (.Clk, .rstN, .cfg, .ramEnabled(bankBus.ramEnabled), .probeDone,
                       .busValid, .busReady, .busWrite, .busAddr, .busWData,
                       .rspValid, .rspData,
                       .romValid, .romReady, .romAddr, .romRspValid, .romData,
                       .ramValid, .ramReady, .ramWrite, .ramAddr, .ramWData,
                       .ramRspValid, .ramRData,
                       .probeValid, .probeAddr, .probeReady, .probeRspValid, .probeData,
                       .regWrite, .regAddr, .regData, .imgAddr, .ramMapAddr, .cpuAddr);

endmodule

//--- bench/cartMapper_props.sv
//====================================================================
// Handshake rules checked on the top level through bind
// Checks are off while reset is low
//====================================================================
`include "cartMapper_cfg.svh"

module cartMapper_props
(
    input logic Clk,
    input logic rstN,
    input logic busReady,
    input logic rspValid,
    input logic romValid,
    input logic romReady,
    input logic [`IMG_AW-1:0] romAddr,
    input logic ramValid,
    input logic ramReady,
    input logic [`RAM_AW-1:0] ramAddr
);

    // Image request held until taken
    romHold: assert property (@(posedge Clk) disable iff (!rstN)
        romValid && !romReady |=> romValid && $stable(romAddr))
        else $error("romValid or romAddr changed before romReady");

    // RAM request held until taken
    ramHold: assert property (@(posedge Clk) disable iff (!rstN)
        ramValid && !ramReady |=> ramValid && $stable(ramAddr))
        else $error("ramValid or ramAddr changed before ramReady");

    // Only one request in flight
    rspBusy: assert property (@(posedge Clk) disable iff (!rstN)
        !(rspValid && busReady))
        else $error("rspValid while busReady is high");

endmodule

bind cartMapper cartMapper_props props0
(
    .Clk(Clk),
    .rstN(rstN),
    .busReady(busReady),
    .rspValid(rspValid),
    .romValid(romValid),
    .romReady(romReady),
    .romAddr(romAddr),
    .ramValid(ramValid),
    .ramReady(ramReady),
    .ramAddr(ramAddr)
);

//--- bench/cartMapper_tb.sv
//====================================================================
// Testbench for the cartridge bank controller
// Vectors are read from bench/cartMapper_vectors.txt, run from root
// Image byte is bank[7:0] ^ addr[7:0], bank bit 8 flips bit 7
// Header bytes 0x147-0x149 come from each section record
// Memory models answer after 0-3 cycles of LCG delay
//====================================================================
`include "cartMapper_cfg.svh"

module cartMapper_tb;

    localparam int VEC_WORDS = 256;
    localparam int TIMEOUT = 200;
    localparam int RAM_BYTES = 1 << `RAM_AW;
    localparam logic [31:0] SEED = 32'ha284_f394;

    logic Clk;
    logic rstN;
    logic busValid;
    logic busReady;
    logic busWrite;
    logic [`CPU_AW-1:0] busAddr;
    logic [`DW-1:0] busWData;
    logic rspValid;
    logic [`DW-1:0] rspData;
    logic romValid;
    logic romReady;
    logic [`IMG_AW-1:0] romAddr;
    logic romRspValid;
    logic [`DW-1:0] romData;
    logic ramValid;
    logic ramReady;
    logic ramWrite;
    logic [`RAM_AW-1:0] ramAddr;
    logic [`DW-1:0] ramWData;
    logic ramRspValid;
    logic [`DW-1:0] ramRData;

    // Header of the current section
    logic [7:0] hdrType;
    logic [7:0] hdrRom;
    logic [7:0] hdrRam;
    logic [15:0] vecMem [0:VEC_WORDS-1];
    logic [7:0] ramMem [0:RAM_BYTES-1];
    logic [31:0] romLcg;
    logic [31:0] ramLcg;
    int tests;
    int errors;

    cartMapper dut0 (.Clk, .rstN, .busValid, .busReady, .busWrite, .busAddr, .busWData,
                     .rspValid, .rspData, .romValid, .romReady, .romAddr, .romRspValid,
                     .romData, .ramValid, .ramReady, .ramWrite, .ramAddr, .ramWData,
                     .ramRspValid, .ramRData);

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Load image contents seen by the DUT
    function automatic logic [7:0] imageByte(input logic [`IMG_AW-1:0] a);
        logic [8:0] bankNo;
        bankNo = a[22:14];
        if (a == `HDR_TYPE)
            return hdrType;
        if (a == `HDR_ROM)
            return hdrRom;
        if (a == `HDR_RAM)
            return hdrRam;
        return bankNo[7:0] ^ a[7:0] ^ {bankNo[8], 7'd0};
    endfunction

    // RAM power-up pattern, every address bit takes part
    function automatic logic [7:0] ramFill(input logic [`RAM_AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ {a[16], 7'h5A};
    endfunction

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    //====================================================================
    // Image model
    //====================================================================
    initial
    begin
        logic [1:0] delay;
        logic [`IMG_AW-1:0] addr;
        romReady = 1'b0;
        romRspValid = 1'b0;
        romData = '0;
        romLcg = SEED;
        forever
        begin
            @(posedge Clk);
            #1;
            romRspValid = 1'b0;
            if (rstN && romValid)
            begin
                romLcg = lcgNext(romLcg);
                delay = romLcg[17:16];
                repeat (delay)
                begin
                    @(posedge Clk);
                    #1;
                end
                romReady = 1'b1;
                addr = romAddr;
                @(posedge Clk);
                #1;
                romReady = 1'b0;
                romLcg = lcgNext(romLcg);
                delay = romLcg[17:16];
                repeat (delay)
                begin
                    @(posedge Clk);
                    #1;
                end
                romData = imageByte(addr);
                romRspValid = 1'b1;
            end
        end
    end

    //====================================================================
    // Cartridge RAM model, refilled during each reset
    //====================================================================
    initial
    begin
        logic [1:0] delay;
        logic [`RAM_AW-1:0] addr;
        logic wr;
        logic [7:0] wdata;
        logic filled;
        ramReady = 1'b0;
        ramRspValid = 1'b0;
        ramRData = '0;
        ramLcg = SEED;
        filled = 1'b0;
        forever
        begin
            @(posedge Clk);
            #1;
            ramRspValid = 1'b0;
            if (!rstN)
            begin
                if (!filled)
                begin
                    for (int i = 0; i < RAM_BYTES; i++)
                        ramMem[i] = ramFill(i[`RAM_AW-1:0]);
                end
                filled = 1'b1;
            end
            else if (ramValid)
            begin
                filled = 1'b0;
                ramLcg = lcgNext(ramLcg);
                delay = ramLcg[17:16];
                repeat (delay)
                begin
                    @(posedge Clk);
                    #1;
                end
                ramReady = 1'b1;
                addr = ramAddr;
                wr = ramWrite;
                wdata = ramWData;
                @(posedge Clk);
                #1;
                ramReady = 1'b0;
                if (wr)
                    ramMem[addr] = wdata;
                ramLcg = lcgNext(ramLcg);
                delay = ramLcg[17:16];
                repeat (delay)
                begin
                    @(posedge Clk);
                    #1;
                end
                ramRData = wr ? 8'h00 : ramMem[addr];
                ramRspValid = 1'b1;
            end
            else
                filled = 1'b0;
        end
    end

    // New header bytes, then reset for 2 cycles
    task automatic startSection(input logic [7:0] cartType, input logic [7:0] romCode,
                                input logic [7:0] ramCode);
        hdrType = cartType;
        hdrRom = romCode;
        hdrRam = ramCode;
        $display("section: type %h, ROM code %h, RAM code %h", cartType, romCode, ramCode);
        rstN = 1'b0;
        repeat (2) @(posedge Clk);
        #1;
        rstN = 1'b1;
    endtask

    // One CPU request, waits counts cycles after the first one
    task automatic busOp(input logic wr, input logic [15:0] addr, input logic [7:0] wdata,
                         output logic [7:0] rdata, output int waits, output logic ok);
        int count;
        ok = 1'b0;
        rdata = '0;
        waits = 0;
        count = 0;
        while (!busReady && count < TIMEOUT)
        begin
            @(posedge Clk);
            #1;
            count++;
        end
        if (busReady)
        begin
            busValid = 1'b1;
            busWrite = wr;
            busAddr = addr;
            busWData = wdata;
            @(posedge Clk);
            #1;
            busValid = 1'b0;
            busWrite = 1'b0;
            while (!rspValid && waits < TIMEOUT)
            begin
                @(posedge Clk);
                #1;
                waits++;
            end
            ok = rspValid;
            rdata = rspData;
        end
    endtask

    //====================================================================
    // Vector walk and checks
    //====================================================================
    initial
    begin
        int idx;
        int waits;
        int testErrs;
        logic [15:0] op;
        logic [15:0] addr;
        logic [7:0] expData;
        logic [7:0] rdata;
        logic ok;
        logic done;
        logic ramOn;
        logic quick;
        rstN = 1'b0;
        busValid = 1'b0;
        busWrite = 1'b0;
        busAddr = '0;
        busWData = '0;
        hdrType = '0;
        hdrRom = '0;
        hdrRam = '0;
        tests = 0;
        errors = 0;
        idx = 0;
        done = 1'b0;
        ramOn = 1'b0;
        $readmemh("bench/cartMapper_vectors.txt", vecMem);
        @(posedge Clk);
        #1;
        while (!done && idx + 2 < VEC_WORDS)
        begin
            op = vecMem[idx];
            addr = vecMem[idx + 1];
            expData = vecMem[idx + 2][7:0];
            idx = idx + 3;
            if (op == 16'h0001)
            begin
                ramOn = 1'b0;
                startSection(addr[15:8], addr[7:0], expData);
            end
            else if (op == 16'h0002 || op == 16'h0003)
            begin
                // Register writes, unmapped addresses and idle RAM answer in 1 cycle
                quick = (op == 16'h0002 && !addr[15]) ||
                        (addr[15] && (addr[15:13] != 3'b101 || !ramOn ||
                         !(hdrType inside {8'h02, 8'h03, 8'h08, 8'h09,
                                           8'h1A, 8'h1B, 8'h1D, 8'h1E})));
                busOp(op == 16'h0002, addr, expData, rdata, waits, ok);
                tests++;
                testErrs = 0;
                if (!ok)
                begin
                    $display("Timeout: request to %h got no response", addr);
                    testErrs++;
                    done = 1'b1;
                end
                if (ok && op == 16'h0003 && rdata != expData)
                begin
                    $display("** Error at %0t: read %h returned %h, expected %h",
                             $time, addr, rdata, expData);
                    testErrs++;
                end
                if (ok && op == 16'h0002 && rdata != 8'h00)
                begin
                    $display("** Error at %0t: write %h returned %h, expected 00",
                             $time, addr, rdata);
                    testErrs++;
                end
                if (ok && quick && waits != 0)
                begin
                    $display("** Error at %0t: request %h took %0d extra cycles",
                             $time, addr, waits);
                    testErrs++;
                end
                // RAM enable follows the low nibble written below 0x2000
                if (op == 16'h0002 && addr[15:13] == 3'b000)
                    ramOn = (expData[3:0] == 4'hA);
                errors += testErrs;
                $display("test %0d: %s %h data %h: %s", tests,
                         (op == 16'h0002) ? "write" : "read", addr, expData,
                         (testErrs == 0) ? "ok" : "FAIL");
            end
            else
                done = 1'b1;
        end
        if (tests == 0)
        begin
            $display("No test vectors were read");
            errors++;
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- bench/cartMapper_vectors.txt
// Records of three hex words: op addr data
// op 1 starts a section: addr is {type, ROM code}, data is the RAM code
// op 2 writes data to addr, op 3 reads addr and expects data, op F ends
// ROM-only, 32 KiB
1 0000 00
3 4123 22
3 0050 50
// MBC1, 512 KiB, bank 0 becomes 1
1 0104 00
2 2000 00
3 4010 11
2 2000 13
3 4020 33
// MBC1, 256 KiB masks bank 0x13 to 0x03
1 0103 00
2 2000 13
3 4020 23
// MBC1, 2 MiB, mode 1 moves the lower window
1 0106 00
2 6000 01
2 4000 02
3 0033 73
2 2000 05
3 4001 44
// MBC5, 8 MiB, bank 0 and bank 0x100
1 1908 00
2 2000 00
3 4055 55
2 3000 01
3 4055 D5
// MBC5 with 128 KiB RAM
1 1B02 04
3 A010 00
2 A010 77
2 0000 0A
3 A010 4A
2 4000 03
2 A010 C3
3 A010 C3
2 4000 02
3 A010 0A
2 A010 3C
3 A010 3C
2 4000 03
3 A010 C3
// Unsupported type 0x0F
1 0F02 00
3 4011 10
2 2000 05
3 4011 10
3 0022 22
F 0000 00

//--- cartMapper.f
+incdir+design
design/cartMapperPkg.sv
design/bankIf.sv
design/headerProbe.sv
design/bankRegs.sv
design/bankTranslate.sv
design/busRouter.sv
design/cartMapper.sv
bench/cartMapper_props.sv
bench/cartMapper_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge mapper testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cartMapper.f --top-module cartMapper_tb \
    -o cartMapper_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/cartMapper_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
